// File: common/outlier_config.svh
`ifndef OUTLIER_CONFIG_SVH
`define OUTLIER_CONFIG_SVH

// Vector geometry
`define OUT_NUM_CHANNELS 8
`define OUT_ELEM_WIDTH 16

// Coarse magnitude code taken just below the sign bit
`define OUT_CODE_WIDTH 4

// Index list capacity, also the ceiling for the programmed limit
`define OUT_MAX_OUTLIERS 4

// APB register map
`define OUT_ADDR_CTRL 4'h0
`define OUT_ADDR_THRESH 4'h4
`define OUT_ADDR_COUNT 4'h8

// CTRL field positions
`define OUT_CTRL_ENABLE_BIT 0
`define OUT_CTRL_MAX_LSB 4
`define OUT_CTRL_MAX_MSB 6

`endif

// File: common/outlier_types_pkg.sv
`include "outlier_config.svh"

package outlier_types_pkg;

    // One signed channel
    typedef logic signed [`OUT_ELEM_WIDTH-1:0] elem_t;

    typedef logic [`OUT_CODE_WIDTH-1:0] code_t;  // Ones' complement magnitude estimate

    typedef logic [$clog2(`OUT_NUM_CHANNELS)-1:0] chan_idx_t;

    typedef logic [`OUT_NUM_CHANNELS-1:0] chan_mask_t;  // Bit i set means channel i is an outlier

    // Holds 0 up to the list capacity inclusive
    typedef logic [$clog2(`OUT_MAX_OUTLIERS+1)-1:0] count_t;

    typedef elem_t [`OUT_NUM_CHANNELS-1:0] vector_t;

    typedef chan_idx_t [`OUT_MAX_OUTLIERS-1:0] idx_list_t;  // Slot 0 is the lowest channel

    // Output of one magnitude lane
    typedef struct packed {
        elem_t value;
        code_t code;
        logic  flag;
    } lane_result_t;

    // Selector output, one per delivered vector
    typedef struct packed {
        vector_t    outliers;
        vector_t    inliers;
        chan_mask_t mask;
        idx_list_t  indices;
        count_t     count;
    } split_result_t;

endpackage

// File: common/outlier_regs_pkg.sv
package outlier_regs_pkg;

    typedef logic [3:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;  // Also the width of the vector counter

    // Master side of the bus
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // Live configuration seen by the datapath
    typedef struct packed {
        logic                      enable;
        outlier_types_pkg::count_t max_outliers;  // Already clamped
        outlier_types_pkg::code_t  threshold;
    } cfg_t;

endpackage

// File: src/outlier_csr.sv
`timescale 1ns/1ps
`include "outlier_config.svh"

module outlier_csr (
    input  logic                       clk,
    input  logic                       rst,
    input  outlier_regs_pkg::apb_req_t apb_req,
    output outlier_regs_pkg::apb_rsp_t apb_rsp,
    input  logic                       delivered,
    output outlier_regs_pkg::cfg_t     cfg
);

    outlier_regs_pkg::cfg_t      cfg_q;
    outlier_regs_pkg::apb_data_t count_q;
    outlier_regs_pkg::apb_data_t rdata;
    outlier_types_pkg::count_t   max_wr;

    logic access;
    logic wr_en;
    logic addr_ctrl;
    logic addr_thresh;
    logic addr_count;
    logic mapped;

    assign access = apb_req.psel && apb_req.penable;  // No wait states
    assign wr_en  = access && apb_req.pwrite;

    assign addr_ctrl   = (apb_req.paddr == `OUT_ADDR_CTRL);
    assign addr_thresh = (apb_req.paddr == `OUT_ADDR_THRESH);
    assign addr_count  = (apb_req.paddr == `OUT_ADDR_COUNT);
    assign mapped      = addr_ctrl || addr_thresh || addr_count;

    // Saturate the limit at the list capacity
    assign max_wr = (apb_req.pwdata[`OUT_CTRL_MAX_MSB:`OUT_CTRL_MAX_LSB] > `OUT_MAX_OUTLIERS) ?
                    outlier_types_pkg::count_t'(`OUT_MAX_OUTLIERS) :
                    apb_req.pwdata[`OUT_CTRL_MAX_MSB:`OUT_CTRL_MAX_LSB];

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q <= '0;
        end else if (wr_en) begin
            if (addr_ctrl) begin
                cfg_q.enable       <= apb_req.pwdata[`OUT_CTRL_ENABLE_BIT];
                cfg_q.max_outliers <= max_wr;
            end
            if (addr_thresh) begin
                cfg_q.threshold <= apb_req.pwdata[`OUT_CODE_WIDTH-1:0];
            end
        end
    end

    // Output handshakes, wraps naturally
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (delivered) begin
            count_q <= count_q + 1'b1;
        end
    end

    always_comb begin
        rdata = '0;  // Unmapped reads return zero
        if (addr_ctrl) begin
            rdata[`OUT_CTRL_ENABLE_BIT]                 = cfg_q.enable;
            rdata[`OUT_CTRL_MAX_MSB:`OUT_CTRL_MAX_LSB] = cfg_q.max_outliers;
        end
        if (addr_thresh) begin
            rdata[`OUT_CODE_WIDTH-1:0] = cfg_q.threshold;
        end
        if (addr_count) begin
            rdata = count_q;
        end
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    // COUNT is read only
    assign apb_rsp.pslverr = access && (!mapped || (addr_count && apb_req.pwrite));

    assign cfg = cfg_q;

endmodule

// File: src/vector_ingress.sv
`timescale 1ns/1ps
`include "outlier_config.svh"

module vector_ingress (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       advance,
    input  logic                       in_valid,
    input  outlier_types_pkg::vector_t in_vec,
    output logic                       lane_valid,
    output outlier_types_pkg::vector_t lane_elems
);

    logic                       valid_q;
    outlier_types_pkg::vector_t vec_q;

    // Stage valid, a bubble is loaded when nothing is offered
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= in_valid;
        end
    end

    // Payload only moves on an actual transfer
    always_ff @(posedge clk) begin
        if (advance && in_valid) begin
            vec_q <= in_vec;
        end
    end

    assign lane_valid = valid_q;

    // Lane ch picks element ch
    for (genvar ch = 0; ch < `OUT_NUM_CHANNELS; ch++) begin : g_dist
        assign lane_elems[ch] = vec_q[ch];
    end

endmodule

// File: src/magnitude_lane.sv
`timescale 1ns/1ps
`include "outlier_config.svh"

module magnitude_lane (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            advance,
    input  outlier_types_pkg::elem_t        elem,
    input  outlier_types_pkg::code_t        threshold,
    output outlier_types_pkg::lane_result_t result
);

    localparam int SIGN_BIT = `OUT_ELEM_WIDTH - 1;

    outlier_types_pkg::code_t        code;
    outlier_types_pkg::lane_result_t result_q;
    logic                            sign;
    logic                            flag;

    assign sign = elem[SIGN_BIT];

    // Bits under the sign, flipped for negatives
    assign code = elem[SIGN_BIT-1 -: `OUT_CODE_WIDTH] ^ {`OUT_CODE_WIDTH{sign}};

    assign flag = (code >= threshold);  // Threshold 0 flags everything

    always_ff @(posedge clk) begin
        if (advance) begin
            result_q.value <= elem;
            result_q.code  <= code;
        end
    end

    // Flag cleared so no stale outlier survives reset
    always_ff @(posedge clk) begin
        if (rst) begin
            result_q.flag <= 1'b0;
        end else if (advance) begin
            result_q.flag <= flag;
        end
    end

    assign result = result_q;

endmodule

// File: outlier_select/outlier_select.sv
`timescale 1ns/1ps
`include "outlier_config.svh"

module outlier_select (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             advance,
    input  logic                             in_valid,
    input  outlier_types_pkg::lane_result_t  lanes [`OUT_NUM_CHANNELS],
    input  outlier_regs_pkg::cfg_t           cfg,
    output logic                             out_valid,
    output outlier_types_pkg::split_result_t out_result
);

    outlier_types_pkg::chan_mask_t    mask_c;
    outlier_types_pkg::idx_list_t     idx_c;
    outlier_types_pkg::count_t        cnt_c;
    outlier_types_pkg::vector_t       outliers_c;
    outlier_types_pkg::vector_t       inliers_c;
    outlier_types_pkg::split_result_t result_q;

    logic valid_q;

    // Lowest channel wins, stop once the limit is reached
    always_comb begin
        mask_c = '0;
        idx_c  = '0;  // Unused slots stay zero
        cnt_c  = '0;
        for (int i = 0; i < `OUT_NUM_CHANNELS; i++) begin
            if (cfg.enable && lanes[i].flag && (cnt_c < cfg.max_outliers)) begin
                mask_c[i]    = 1'b1;
                idx_c[cnt_c] = outlier_types_pkg::chan_idx_t'(i);
                cnt_c        = cnt_c + 1'b1;
            end
        end
    end

    // Mask steers each value to exactly one side
    always_comb begin
        outliers_c = '0;
        inliers_c  = '0;
        for (int i = 0; i < `OUT_NUM_CHANNELS; i++) begin
            if (mask_c[i]) begin
                outliers_c[i] = lanes[i].value;
            end else begin
                inliers_c[i] = lanes[i].value;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= in_valid;
        end
    end

    // Result held while the sink stalls
    always_ff @(posedge clk) begin
        if (advance && in_valid) begin
            result_q.outliers <= outliers_c;
            result_q.inliers  <= inliers_c;
            result_q.mask     <= mask_c;
            result_q.indices  <= idx_c;
            result_q.count    <= cnt_c;
        end
    end

    assign out_valid  = valid_q;
    assign out_result = result_q;

endmodule

// File: src/outlier_split_top.sv
`timescale 1ns/1ps
`include "outlier_config.svh"

module outlier_split_top (
    input  logic                             clk,
    input  logic                             rst,
    input  outlier_regs_pkg::apb_req_t       apb_req,
    output outlier_regs_pkg::apb_rsp_t       apb_rsp,
    input  logic                             in_valid,
    output logic                             in_ready,
    input  outlier_types_pkg::vector_t       in_vec,
    output logic                             out_valid,
    input  logic                             out_ready,
    output outlier_types_pkg::split_result_t out_result
);

    outlier_regs_pkg::cfg_t          cfg;
    outlier_types_pkg::vector_t      ing_elems;
    outlier_types_pkg::lane_result_t lane_res [`OUT_NUM_CHANNELS];

    logic advance;
    logic delivered;
    logic ing_valid;
    logic lane_valid_q;

    // Single stall for the whole pipe
    assign advance   = !out_valid || out_ready;
    assign in_ready  = advance;
    assign delivered = out_valid && out_ready;

    // Lane stage valid, kept beside the lane array
    always_ff @(posedge clk) begin
        if (rst) begin
            lane_valid_q <= 1'b0;
        end else if (advance) begin
            lane_valid_q <= ing_valid;
        end
    end

    outlier_csr u_csr (
        .clk      (clk),
        .rst      (rst),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .delivered(delivered),
        .cfg      (cfg)
    );

    vector_ingress u_ingress (
        .clk       (clk),
        .rst       (rst),
        .advance   (advance),
        .in_valid  (in_valid),
        .in_vec    (in_vec),
        .lane_valid(ing_valid),
        .lane_elems(ing_elems)
    );

    for (genvar ch = 0; ch < `OUT_NUM_CHANNELS; ch++) begin : g_lane
        magnitude_lane u_lane (
            .clk      (clk),
            .rst      (rst),
            .advance  (advance),
            .elem     (ing_elems[ch]),
            .threshold(cfg.threshold),
            .result   (lane_res[ch])
        );
    end

    outlier_select u_select (
        .clk       (clk),
        .rst       (rst),
        .advance   (advance),
        .in_valid  (lane_valid_q),
        .lanes     (lane_res),
        .cfg       (cfg),
        .out_valid (out_valid),
        .out_result(out_result)
    );

endmodule

// File: testbench/outlier_split_assertions.sv
`timescale 1ns/1ps
`include "outlier_config.svh"

module outlier_split_assertions (
    input logic                             clk,
    input logic                             rst,
    input logic                             out_valid,
    input logic                             out_ready,
    input outlier_types_pkg::split_result_t out_result
);

    int fail_count = 0;  // Read by the testbench at the end

    a_reset_valid: assert property (@(posedge clk) rst |=> !out_valid)
        else begin $error("out_valid high right after reset"); fail_count++; end

    // Held result must not move while the sink stalls
    a_stall_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_result))
        else begin $error("out_result changed during a stall"); fail_count++; end

    a_count_mask: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_result.count == $countones(out_result.mask))
        else begin $error("count disagrees with mask"); fail_count++; end

    for (genvar ch = 0; ch < `OUT_NUM_CHANNELS; ch++) begin : g_disjoint
        a_disjoint: assert property (@(posedge clk) disable iff (rst)
            out_valid |-> (out_result.mask[ch] ? out_result.inliers[ch] == '0
                                               : out_result.outliers[ch] == '0))
            else begin $error("channel %0d on both sides", ch); fail_count++; end
    end

endmodule

// File: testbench/outlier_split_tb.sv
`timescale 1ns/1ps
`include "outlier_config.svh"

module outlier_split_tb;

    localparam int TIMEOUT     = 200;
    localparam int NUM_ENTRIES = 7;

    // Channels 7 down to 0 with codes 0 0 11 8 7 15 1 15
    localparam outlier_types_pkg::vector_t VEC_A = {16'hF800, 16'h0000, 16'hA000, 16'h4000,
                                                    16'hC000, 16'h8000, 16'h0800, 16'h7800};
    // Codes 15 7 then six channels of code 1
    localparam outlier_types_pkg::vector_t VEC_B = {16'h8000, 16'hC000, {6{16'h0800}}};

    typedef struct packed {
        outlier_types_pkg::code_t      thr;
        outlier_types_pkg::count_t     maxo;
        logic                          en;
        outlier_types_pkg::vector_t    vec;
        outlier_types_pkg::chan_mask_t mask;
        outlier_types_pkg::count_t     cnt;
        outlier_types_pkg::idx_list_t  idx;
    } entry_t;

    logic                             clk = 1'b0;
    logic                             rst;
    outlier_regs_pkg::apb_req_t       apb_req;
    outlier_regs_pkg::apb_rsp_t       apb_rsp;
    logic                             in_valid;
    logic                             in_ready;
    outlier_types_pkg::vector_t       in_vec;
    logic                             out_valid;
    logic                             out_ready;
    outlier_types_pkg::split_result_t out_result;

    entry_t                           entries [NUM_ENTRIES];
    outlier_types_pkg::split_result_t exp_q [$];
    outlier_types_pkg::vector_t       rand_q [$];
    integer                           seed       = 13;
    int                               errors     = 0;
    int                               handshakes = 0;
    int                               sent       = 0;
    int                               cyc        = 0;
    int                               acc_cyc    = -1;
    int                               out_cyc    = -1;
    logic                             lat_armed  = 1'b0;
    logic                             ready_rand = 1'b0;

    outlier_split_top uut (.*);

    bind outlier_split_top outlier_split_assertions u_assertions (
        .clk(clk), .rst(rst), .out_valid(out_valid), .out_ready(out_ready),
        .out_result(out_result)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // Random sink stalls
    always @(posedge clk) begin : backpressure
        logic [31:0] r;
        #1;
        if (ready_rand) begin
            r         = $random(seed);
            out_ready = r[0];
        end
    end

    task automatic check_field(input string name, input logic [127:0] exp,
        input logic [127:0] got);
        if (exp !== got) begin
            $display("Fail %s exp=%0h got=%0h", name, exp, got);
            errors++;
        end
    endtask

    function automatic outlier_types_pkg::split_result_t split_by_mask(
        input outlier_types_pkg::vector_t v, input outlier_types_pkg::chan_mask_t m);
        outlier_types_pkg::split_result_t r;
        r      = '0;
        r.mask = m;
        for (int i = 0; i < `OUT_NUM_CHANNELS; i++) begin
            if (m[i]) r.outliers[i] = v[i];
            else r.inliers[i] = v[i];
        end
        return r;
    endfunction

    // Reference model built from the selection rules
    function automatic outlier_types_pkg::split_result_t predict_split(
        input outlier_types_pkg::vector_t v, input outlier_types_pkg::code_t thr,
        input outlier_types_pkg::count_t maxo, input logic en);
        outlier_types_pkg::split_result_t r;
        outlier_types_pkg::code_t         c;
        outlier_types_pkg::chan_mask_t    m;
        outlier_types_pkg::idx_list_t     idx;
        int                               n;
        m   = '0;
        idx = '0;
        n   = 0;
        for (int i = 0; i < `OUT_NUM_CHANNELS; i++) begin
            c = v[i][`OUT_ELEM_WIDTH-2 -: `OUT_CODE_WIDTH];
            if (v[i][`OUT_ELEM_WIDTH-1]) c = ~c;
            if (en && c >= thr && n < maxo) begin
                m[i]   = 1'b1;
                idx[n] = outlier_types_pkg::chan_idx_t'(i);
                n++;
            end
        end
        r         = split_by_mask(v, m);
        r.indices = idx;
        r.count   = outlier_types_pkg::count_t'(n);
        return r;
    endfunction

    task automatic apb_transfer(input logic wr, input outlier_regs_pkg::apb_addr_t addr,
        input outlier_regs_pkg::apb_data_t wdata, output outlier_regs_pkg::apb_data_t rdata,
        output logic err);
        int t;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        #1 apb_req.penable = 1'b1;  // Access phase
        t = 0;
        @(negedge clk);
        while (!apb_rsp.pready && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!apb_rsp.pready) begin
            $display("Error: APB access to %0h never completed", addr);
            errors++;
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #1 apb_req = '0;
    endtask

    task automatic apb_write(input outlier_regs_pkg::apb_addr_t addr,
        input outlier_regs_pkg::apb_data_t data, output logic err);
        outlier_regs_pkg::apb_data_t unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input outlier_regs_pkg::apb_addr_t addr,
        output outlier_regs_pkg::apb_data_t data, output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    task automatic configure(input logic en, input outlier_types_pkg::count_t maxo,
        input outlier_types_pkg::code_t thr);
        logic err;
        apb_write(`OUT_ADDR_CTRL, {25'd0, maxo, 3'd0, en}, err);
        apb_write(`OUT_ADDR_THRESH, {28'd0, thr}, err);
    endtask

    task automatic send_vec(input outlier_types_pkg::vector_t v);
        int t;
        sent++;
        in_valid = 1'b1;
        in_vec   = v;
        t        = 0;
        @(negedge clk);
        while (!in_ready && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!in_ready) begin
            $display("Error: input vector was never accepted");
            errors++;
        end
        if (lat_armed && acc_cyc < 0) acc_cyc = cyc;
        @(posedge clk);
        #1 in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        if (exp_q.size() != 0) begin
            $display("Error: timed out waiting for out_valid, %0d vectors missing", exp_q.size());
            errors++;
            exp_q.delete();
        end
        @(posedge clk);
        #1;
    endtask

    // Compare every delivered result in order
    always @(negedge clk) begin : monitor
        outlier_types_pkg::split_result_t e;
        if (!rst) begin
            check_field("in_ready", !out_valid || out_ready, in_ready);  // Global advance
        end
        if (!rst && out_valid) begin
            if (lat_armed && out_cyc < 0) out_cyc = cyc;
            if (out_ready) begin
                handshakes++;
                if (exp_q.size() == 0) begin
                    $display("Error: output delivered with no vector outstanding");
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check_field("mask", e.mask, out_result.mask);
                    check_field("count", e.count, out_result.count);
                    check_field("indices", e.indices, out_result.indices);
                    check_field("outliers", e.outliers, out_result.outliers);
                    check_field("inliers", e.inliers, out_result.inliers);
                end
            end
        end
    end

    initial begin
        outlier_regs_pkg::apb_data_t      rd;
        outlier_types_pkg::split_result_t e;
        outlier_types_pkg::vector_t       v;
        logic [31:0]                      r;
        logic                             err;
        outlier_types_pkg::code_t         thr;
        outlier_types_pkg::count_t        maxo;

        rst       = 1'b1;
        apb_req   = '0;
        in_valid  = 1'b0;
        in_vec    = '0;
        out_ready = 1'b1;

        entries[0] = '{4'd8, 3'd4, 1'b1, VEC_A, 8'h35, 3'd4, {3'd5, 3'd4, 3'd2, 3'd0}};
        entries[1] = '{4'd8, 3'd2, 1'b1, VEC_A, 8'h05, 3'd2, {3'd0, 3'd0, 3'd2, 3'd0}};
        entries[2] = '{4'd11, 3'd4, 1'b1, VEC_A, 8'h25, 3'd3, {3'd0, 3'd5, 3'd2, 3'd0}};
        entries[3] = '{4'd0, 3'd4, 1'b0, VEC_A, 8'h00, 3'd0, 12'h000};  // Disabled
        entries[4] = '{4'd0, 3'd3, 1'b1, '0, 8'h07, 3'd3, {3'd0, 3'd2, 3'd1, 3'd0}};
        entries[5] = '{4'd0, 3'd0, 1'b1, VEC_A, 8'h00, 3'd0, 12'h000};
        entries[6] = '{4'd7, 3'd4, 1'b1, VEC_B, 8'hC0, 3'd2, {3'd0, 3'd0, 3'd7, 3'd6}};

        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        // Register map
        apb_write(`OUT_ADDR_CTRL, 32'h31, err);
        check_field("pslverr", 1'b0, err);
        apb_read(`OUT_ADDR_CTRL, rd, err);
        check_field("prdata", 32'h31, rd);
        apb_write(`OUT_ADDR_THRESH, 32'hA, err);
        apb_read(`OUT_ADDR_THRESH, rd, err);
        check_field("prdata", 32'hA, rd);
        apb_write(`OUT_ADDR_CTRL, 32'h71, err);
        apb_read(`OUT_ADDR_CTRL, rd, err);
        check_field("prdata", 32'h41, rd);  // Limit clamped to 4
        apb_write(`OUT_ADDR_COUNT, 32'h1, err);
        check_field("pslverr", 1'b1, err);
        apb_read(4'hC, rd, err);
        check_field("pslverr", 1'b1, err);
        check_field("prdata", 32'h0, rd);

        for (int k = 0; k < NUM_ENTRIES; k++) begin
            configure(entries[k].en, entries[k].maxo, entries[k].thr);
            e         = split_by_mask(entries[k].vec, entries[k].mask);
            e.count   = entries[k].cnt;
            e.indices = entries[k].idx;
            exp_q.push_back(e);
            send_vec(entries[k].vec);
            wait_drain();
        end

        // Back to back with the sink always ready
        configure(1'b1, 3'd4, 4'd6);
        for (int k = 0; k < 8; k++) begin
            for (int ch = 0; ch < `OUT_NUM_CHANNELS; ch++) begin
                r     = $random(seed);
                v[ch] = r[15:0];
            end
            rand_q.push_back(v);
        end
        lat_armed = 1'b1;
        foreach (rand_q[k]) begin
            exp_q.push_back(predict_split(rand_q[k], 4'd6, 3'd4, 1'b1));
            send_vec(rand_q[k]);
        end
        wait_drain();
        lat_armed = 1'b0;
        check_field("latency", 3, out_cyc - acc_cyc);

        // Random configuration under random back-pressure
        r    = $random(seed);
        thr  = r[3:0];
        maxo = outlier_types_pkg::count_t'(r[7:4] % 5);
        configure(1'b1, maxo, thr);
        rand_q.delete();
        for (int k = 0; k < 40; k++) begin
            for (int ch = 0; ch < `OUT_NUM_CHANNELS; ch++) begin
                r     = $random(seed);
                v[ch] = r[15:0];
            end
            rand_q.push_back(v);
        end
        ready_rand = 1'b1;
        foreach (rand_q[k]) begin
            exp_q.push_back(predict_split(rand_q[k], thr, maxo, 1'b1));
            send_vec(rand_q[k]);
        end
        wait_drain();
        ready_rand = 1'b0;
        out_ready  = 1'b1;

        apb_read(`OUT_ADDR_COUNT, rd, err);
        check_field("count_reg", sent, rd);

        errors += uut.u_assertions.fail_count;
        $display("Done with %0d errors over %0d delivered vectors", errors, handshakes);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
common/outlier_types_pkg.sv
common/outlier_regs_pkg.sv
src/outlier_csr.sv
src/vector_ingress.sv
src/magnitude_lane.sv
outlier_select/outlier_select.sv
src/outlier_split_top.sv
testbench/outlier_split_assertions.sv
testbench/outlier_split_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= outlier_split_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)
